// File: source/icache_lookup_pkg.sv
// -------------------------------------------------------------------------
// Shared geometry, widths and port structs of the L1 lookup pipeline.
// Import with a wildcard in the module header where needed.
// -------------------------------------------------------------------------
package icache_lookup_pkg;

  localparam int unsigned FETCH_AW    = 32;
  localparam int unsigned LINE_WIDTH  = 64;
  localparam int unsigned LINE_ALIGN  = 3;
  localparam int unsigned COUNT_ALIGN = 4;
  localparam int unsigned LINE_COUNT  = 16;
  localparam int unsigned WAY_COUNT   = 2;
  localparam int unsigned SET_ALIGN   = 1;
  localparam int unsigned TAG_WIDTH   = FETCH_AW - LINE_ALIGN - COUNT_ALIGN;
  localparam int unsigned ID_WIDTH    = 4;

  typedef logic [FETCH_AW-1:0]    addr_t;
  typedef logic [ID_WIDTH-1:0]    id_t;
  typedef logic [COUNT_ALIGN-1:0] index_t;
  typedef logic [SET_ALIGN-1:0]   set_t;
  typedef logic [TAG_WIDTH-1:0]   tag_t;
  typedef logic [LINE_WIDTH-1:0]  line_t;

  // Word stored per way and index in the tag RAM
  typedef struct packed {
    logic valid;
    logic error;
    tag_t tag;
  } tag_entry_t;

  typedef struct packed {
    addr_t addr;
    id_t   id;
  } lookup_req_t;

  typedef struct packed {
    addr_t addr;
    id_t   id;
    set_t  cset;
    logic  hit;
    logic  error;
    line_t data;
  } lookup_rsp_t;

  typedef struct packed {
    index_t index;
    set_t   cset;
    tag_t   tag;
    line_t  data;
    logic   error;
  } refill_t;

  // Tag stage result handed to the data stage
  typedef struct packed {
    addr_t addr;
    id_t   id;
    set_t  cset;
    logic  hit;
    logic  error;
  } tag_rsp_t;

endpackage

// File: source/sp_ram.sv
// -------------------------------------------------------------------------
// Single-port synchronous RAM with registered read data.
// Read data only changes on a read access.
// -------------------------------------------------------------------------
module sp_ram #(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 16
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  logic [Width-1:0]         wdata_i,
  output logic [Width-1:0]         rdata_o
);

  logic [Width-1:0] mem_q [Depth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// File: source/tag_stage.sv
// -------------------------------------------------------------------------
// Tag stage of the lookup pipeline: init sweep, tag port arbitration,
// per-way tag RAMs, tag compare and a fall-through response buffer.
// -------------------------------------------------------------------------
module tag_stage import icache_lookup_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_valid_i,
  input  lookup_req_t in_req_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  refill_t     refill_i,
  input  logic        write_valid_i,
  output logic        write_ready_o,
  output logic        init_busy_o,
  output tag_rsp_t    tag_rsp_o,
  output logic        tag_valid_o,
  input  logic        tag_ready_i
);

  logic [COUNT_ALIGN:0] init_count_q;
  logic                 init_busy;

  index_t               tag_addr;
  logic [WAY_COUNT-1:0] tag_en;
  logic                 tag_we;
  tag_entry_t           tag_wdata;
  tag_entry_t           tag_rdata [WAY_COUNT];

  logic                 req_ready;
  logic                 accept;
  logic                 req_handshake_q;
  lookup_req_t          tag_req_q;
  logic                 tag_valid_q;

  tag_t                 required_tag;
  logic [WAY_COUNT-1:0] line_hit;
  set_t                 hit_set;
  tag_rsp_t             tag_rsp_s;
  tag_rsp_t             tag_rsp_q;

  // -----------------------------------------------------------------------
  // Init and flush sweep
  // -----------------------------------------------------------------------
  assign init_busy = init_count_q != (COUNT_ALIGN + 1)'(LINE_COUNT);

  // Flush restarts the sweep, but only once the previous one is done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_count_q <= '0;
    end else if (init_busy) begin
      init_count_q <= init_count_q + 1'b1;
    end else if (flush_valid_i) begin
      init_count_q <= '0;
    end
  end

  // -----------------------------------------------------------------------
  // Tag port arbitration: sweep, then refill, then lookup
  // -----------------------------------------------------------------------
  assign req_ready = !tag_valid_q || tag_ready_i;

  always_comb begin
    tag_addr      = in_req_i.addr[LINE_ALIGN +: COUNT_ALIGN];
    tag_en        = '0;
    tag_we        = 1'b0;
    tag_wdata     = '{valid: 1'b1, error: refill_i.error, tag: refill_i.tag};
    write_ready_o = 1'b1;
    in_ready_o    = 1'b0;
    if (init_busy) begin
      tag_addr      = init_count_q[COUNT_ALIGN-1:0];
      tag_en        = '1;
      tag_we        = 1'b1;
      tag_wdata     = '0;
      write_ready_o = 1'b0;
    end else if (write_valid_i) begin
      // Only the selected way takes the refill
      tag_addr               = refill_i.index;
      tag_en[refill_i.cset]  = 1'b1;
      tag_we                 = 1'b1;
    end else if (in_valid_i) begin
      tag_en     = {WAY_COUNT{req_ready}};
      in_ready_o = req_ready;
    end
  end

  assign accept = in_valid_i && in_ready_o;

  for (genvar i = 0; i < WAY_COUNT; i++) begin : gen_ways
    sp_ram #(
      .Width ($bits(tag_entry_t)),
      .Depth (LINE_COUNT)
    ) i_tag_ram (
      .clk_i   (clk_i),
      .req_i   (tag_en[i]),
      .we_i    (tag_we),
      .addr_i  (tag_addr),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[i])
    );

    assign line_hit[i] = tag_rdata[i].valid && (tag_rdata[i].tag == required_tag);
  end

  // -----------------------------------------------------------------------
  // Request register and compare
  // -----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tag_req_q <= in_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_valid_q     <= 1'b0;
      req_handshake_q <= 1'b0;
    end else begin
      req_handshake_q <= accept;
      if (accept) begin
        tag_valid_q <= 1'b1;
      end else if (tag_ready_i) begin
        tag_valid_q <= 1'b0;
      end
    end
  end

  assign required_tag = tag_req_q.addr[FETCH_AW-1 -: TAG_WIDTH];

  // Lowest-numbered hitting way wins
  always_comb begin
    hit_set = '0;
    for (int i = WAY_COUNT - 1; i >= 0; i--) begin
      if (line_hit[i]) begin
        hit_set = set_t'(i);
      end
    end
  end

  assign tag_rsp_s.addr  = tag_req_q.addr;
  assign tag_rsp_s.id    = tag_req_q.id;
  assign tag_rsp_s.cset  = hit_set;
  assign tag_rsp_s.hit   = |line_hit;
  assign tag_rsp_s.error = line_hit[hit_set] && tag_rdata[hit_set].error;

  // Fall-through buffer, loaded when fresh RAM data meets a stall
  always_ff @(posedge clk_i) begin
    if (req_handshake_q && !tag_ready_i) begin
      tag_rsp_q <= tag_rsp_s;
    end
  end

  assign tag_rsp_o   = req_handshake_q ? tag_rsp_s : tag_rsp_q;
  assign tag_valid_o = tag_valid_q;
  assign init_busy_o = init_busy;

  // -----------------------------------------------------------------------
  // Assertions
  // -----------------------------------------------------------------------
  a_tag_rsp_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    tag_valid_o && !tag_ready_i |=> $stable(tag_rsp_o)
  );

endmodule

// File: source/data_stage.sv
// -------------------------------------------------------------------------
// Data stage of the lookup pipeline. Shares the refill with the tag stage,
// reads the line on a hit and buffers the read data under back-pressure.
// -------------------------------------------------------------------------
module data_stage import icache_lookup_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        init_busy_i,
  input  refill_t     refill_i,
  input  logic        write_valid_i,
  input  tag_rsp_t    tag_rsp_i,
  input  logic        tag_valid_i,
  output logic        tag_ready_o,
  output lookup_rsp_t out_rsp_o,
  output logic        out_valid_o,
  input  logic        out_ready_i
);

  logic [SET_ALIGN+COUNT_ALIGN-1:0] data_addr;
  logic                             data_req;
  logic                             data_write;
  line_t                            data_rdata;

  logic                             tag_take;
  tag_rsp_t                         data_req_q;
  logic                             data_valid_q;
  logic                             read_pending_q;
  line_t                            data_rsp_q;
  line_t                            line_data;

  // -----------------------------------------------------------------------
  // Data port: refill write, otherwise read on a taken hit
  // -----------------------------------------------------------------------
  // Same condition as the tag write so both RAM writes land together
  assign data_write = write_valid_i && !init_busy_i;

  assign tag_ready_o = (!data_valid_q || out_ready_i) && !data_write;
  assign tag_take    = tag_valid_i && tag_ready_o;

  always_comb begin
    data_addr = {tag_rsp_i.cset, tag_rsp_i.addr[LINE_ALIGN +: COUNT_ALIGN]};
    data_req  = tag_take && tag_rsp_i.hit;
    if (data_write) begin
      data_addr = {refill_i.cset, refill_i.index};
      data_req  = 1'b1;
    end
  end

  sp_ram #(
    .Width (LINE_WIDTH),
    .Depth (LINE_COUNT * WAY_COUNT)
  ) i_data_ram (
    .clk_i   (clk_i),
    .req_i   (data_req),
    .we_i    (data_write),
    .addr_i  (data_addr),
    .wdata_i (refill_i.data),
    .rdata_o (data_rdata)
  );

  // -----------------------------------------------------------------------
  // Metadata register and read-data buffer
  // -----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (tag_take) begin
      data_req_q <= tag_rsp_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_valid_q   <= 1'b0;
      read_pending_q <= 1'b0;
    end else begin
      read_pending_q <= tag_take && tag_rsp_i.hit;
      if (tag_take) begin
        data_valid_q <= 1'b1;
      end else if (out_ready_i) begin
        data_valid_q <= 1'b0;
      end
    end
  end

  // Keep the fresh line if the consumer stalls
  always_ff @(posedge clk_i) begin
    if (read_pending_q && !out_ready_i) begin
      data_rsp_q <= data_rdata;
    end
  end

  // Misses return an all-zero line
  always_comb begin
    line_data = '0;
    if (data_req_q.hit) begin
      line_data = read_pending_q ? data_rdata : data_rsp_q;
    end
  end

  assign out_rsp_o.addr  = data_req_q.addr;
  assign out_rsp_o.id    = data_req_q.id;
  assign out_rsp_o.cset  = data_req_q.cset;
  assign out_rsp_o.hit   = data_req_q.hit;
  assign out_rsp_o.error = data_req_q.error;
  assign out_rsp_o.data  = line_data;
  assign out_valid_o     = data_valid_q;

  a_out_rsp_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> $stable(out_rsp_o)
  );

endmodule

// File: source/icache_lookup.sv
// -------------------------------------------------------------------------
// Two-stage L1 instruction-cache lookup: tag stage followed by data stage.
// Refills and flushes enter beside the lookup request stream.
// -------------------------------------------------------------------------
module icache_lookup import icache_lookup_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_valid_i,
  input  lookup_req_t in_req_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  refill_t     refill_i,
  input  logic        write_valid_i,
  output logic        write_ready_o,
  output lookup_rsp_t out_rsp_o,
  output logic        out_valid_o,
  input  logic        out_ready_i
);

  tag_rsp_t tag_rsp;
  logic     tag_valid;
  logic     tag_ready;
  logic     init_busy;

  tag_stage i_tag_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_valid_i (flush_valid_i),
    .in_req_i      (in_req_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .refill_i      (refill_i),
    .write_valid_i (write_valid_i),
    .write_ready_o (write_ready_o),
    .init_busy_o   (init_busy),
    .tag_rsp_o     (tag_rsp),
    .tag_valid_o   (tag_valid),
    .tag_ready_i   (tag_ready)
  );

  data_stage i_data_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .init_busy_i   (init_busy),
    .refill_i      (refill_i),
    .write_valid_i (write_valid_i),
    .tag_rsp_i     (tag_rsp),
    .tag_valid_i   (tag_valid),
    .tag_ready_o   (tag_ready),
    .out_rsp_o     (out_rsp_o),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i)
  );

endmodule

// File: tests/lookup_checker.sv
// ---------------------------------------------------------------------------
// Response checker of the lookup pipeline testbench. Queues the expected
// responses, compares them with accepted DUT responses and counts errors.
// ---------------------------------------------------------------------------
module lookup_checker import icache_lookup_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        push_i,
  input  lookup_rsp_t expected_i,
  input  lookup_rsp_t rsp_i,
  input  logic        valid_i,
  input  logic        ready_i,
  output int unsigned checked_o,
  output int unsigned value_errors_o,
  output int unsigned protocol_errors_o,
  output int unsigned pending_o
);
  timeunit 1ns;
  timeprecision 1ps;

  lookup_rsp_t expect_q [$];
  lookup_rsp_t exp_rsp;
  lookup_rsp_t held_rsp;
  logic        held            = 1'b0;
  int unsigned checked         = 0;
  int unsigned value_errors    = 0;
  int unsigned protocol_errors = 0;
  int unsigned pending         = 0;

  task automatic check_field(input string name, input line_t got, input line_t want);
    if (got !== want) begin
      $display("error at %0t ns: out_rsp_o.%s is %h, expected %h", $time, name, got, want);
      value_errors++;
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (push_i) begin
        expect_q.push_back(expected_i);
      end

      // A stalled response must stay valid and unchanged
      if (held && !valid_i) begin
        $display("out_valid_o dropped at %0t ns before the response was taken", $time);
        protocol_errors++;
      end else if (held && rsp_i !== held_rsp) begin
        $display("out_rsp_o changed at %0t ns while the consumer stalled", $time);
        protocol_errors++;
      end

      if (valid_i && ready_i) begin
        if (expect_q.size() == 0) begin
          $display("response id %0d at %0t ns with no lookup outstanding", rsp_i.id, $time);
          protocol_errors++;
        end else begin
          exp_rsp = expect_q.pop_front();
          check_field("addr", line_t'(rsp_i.addr), line_t'(exp_rsp.addr));
          check_field("id", line_t'(rsp_i.id), line_t'(exp_rsp.id));
          check_field("cset", line_t'(rsp_i.cset), line_t'(exp_rsp.cset));
          check_field("hit", line_t'(rsp_i.hit), line_t'(exp_rsp.hit));
          check_field("error", line_t'(rsp_i.error), line_t'(exp_rsp.error));
          check_field("data", rsp_i.data, exp_rsp.data);
          checked++;
        end
      end

      held     = valid_i && !ready_i;
      held_rsp = rsp_i;
      pending  = expect_q.size();
    end
  end

  assign checked_o         = checked;
  assign value_errors_o    = value_errors;
  assign protocol_errors_o = protocol_errors;
  assign pending_o         = pending;

endmodule

// File: tests/tb_icache_lookup.sv
// ---------------------------------------------------------------------------
// Testbench of the two-stage lookup pipeline. Drives refills, flushes and
// lookups against a cache model; lookup_checker compares the responses.
// ---------------------------------------------------------------------------
module tb_icache_lookup import icache_lookup_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CLK_HALF       = 20;
  localparam int unsigned RESET_CYCLES   = 16;
  localparam int unsigned DIRECTED_OPS   = 40;
  localparam int unsigned PRIME_LEN      = 8;
  localparam int unsigned STREAM_LEN     = 200;
  localparam int unsigned MIX_LEN        = 150;
  localparam int unsigned OP_CYCLES      = 6;
  localparam int unsigned SWEEP_COUNT    = 2;
  localparam int unsigned TIMEOUT_CYCLES = 4 * (OP_CYCLES * (DIRECTED_OPS + PRIME_LEN
                                           + STREAM_LEN + MIX_LEN)
                                           + SWEEP_COUNT * LINE_COUNT + RESET_CYCLES);

  logic        clk_i;
  logic        rst_ni;
  logic        flush_valid;
  lookup_req_t in_req;
  logic        in_valid;
  logic        in_ready;
  refill_t     refill;
  logic        write_valid;
  logic        write_ready;
  lookup_rsp_t out_rsp;
  logic        out_valid;
  logic        out_ready;
  lookup_rsp_t expected;
  logic        lookup_push;
  logic        random_ready;
  logic [31:0] rng;
  logic [31:0] ready_rng;
  id_t         next_id;
  int unsigned tb_errors;
  int unsigned cycle_count = 0;
  int unsigned checked;
  int unsigned value_errors;
  int unsigned protocol_errors;
  int unsigned outstanding;

  // Cache contents as the refills and flushes leave them
  tag_entry_t  model_tag  [WAY_COUNT][LINE_COUNT];
  line_t       model_data [WAY_COUNT][LINE_COUNT];

  icache_lookup dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_valid_i (flush_valid),
    .in_req_i      (in_req),
    .in_valid_i    (in_valid),
    .in_ready_o    (in_ready),
    .refill_i      (refill),
    .write_valid_i (write_valid),
    .write_ready_o (write_ready),
    .out_rsp_o     (out_rsp),
    .out_valid_o   (out_valid),
    .out_ready_i   (out_ready)
  );

  assign lookup_push = in_valid && in_ready;

  lookup_checker rsp_check (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .push_i            (lookup_push),
    .expected_i        (expected),
    .rsp_i             (dut.out_rsp_o),
    .valid_i           (dut.out_valid_o),
    .ready_i           (dut.out_ready_i),
    .checked_o         (checked),
    .value_errors_o    (value_errors),
    .protocol_errors_o (protocol_errors),
    .pending_o         (outstanding)
  );

  // ---------------------------------------------------------------------------
  // Reference model and stimulus helpers
  // ---------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Lowest matching way wins, a miss returns set 0 and a zero line
  function automatic lookup_rsp_t expected_rsp(input lookup_req_t req);
    lookup_rsp_t rsp;
    index_t      idx;
    tag_t        tag;
    idx      = req.addr[LINE_ALIGN +: COUNT_ALIGN];
    tag      = req.addr[FETCH_AW-1 -: TAG_WIDTH];
    rsp      = '0;
    rsp.addr = req.addr;
    rsp.id   = req.id;
    for (int w = WAY_COUNT - 1; w >= 0; w--) begin
      if (model_tag[w][idx].valid && model_tag[w][idx].tag == tag) begin
        rsp.hit   = 1'b1;
        rsp.cset  = set_t'(w);
        rsp.error = model_tag[w][idx].error;
        rsp.data  = model_data[w][idx];
      end
    end
    return rsp;
  endfunction

  // Small tag pool keeps the hit rate high
  function automatic tag_t pool_tag(input logic [1:0] k);
    return tag_t'(32'h0015_a3c1 + 32'(k) * 32'h0040_0107);
  endfunction

  function automatic addr_t make_addr(input tag_t tag, input index_t idx,
                                     input logic [LINE_ALIGN-1:0] off);
    return {tag, idx, off};
  endfunction

  task automatic next_random(output logic [31:0] r);
    rng = xorshift32(rng);
    r   = rng;
  endtask

  task automatic random_line(output line_t d);
    logic [31:0] hi;
    logic [31:0] lo;
    next_random(hi);
    next_random(lo);
    d = {hi, lo};
  endtask

  task automatic random_addr(output addr_t a);
    logic [31:0] r;
    next_random(r);
    a = make_addr(pool_tag(r[9:8]), index_t'(r[5:4]), r[2:0]);
  endtask

  task automatic clear_model();
    for (int w = 0; w < WAY_COUNT; w++) begin
      for (int i = 0; i < LINE_COUNT; i++) begin
        model_tag[w][i]  = '0;
        model_data[w][i] = '0;
      end
    end
  endtask

  // Called on a falling edge
  task automatic present_lookup(input addr_t addr);
    in_req.addr = addr;
    in_req.id   = next_id;
    next_id     = next_id + 1'b1;
    expected    = expected_rsp(in_req);
    in_valid    = 1'b1;
  endtask

  task automatic issue_lookup(input addr_t addr);
    @(negedge clk_i);
    present_lookup(addr);
    @(posedge clk_i);
    while (!in_ready) @(posedge clk_i);
  endtask

  // Lookup presented as a sweep starts, must stay blocked for all of it
  task automatic blocked_lookup(input addr_t addr);
    int unsigned blocked;
    blocked = 0;
    present_lookup(addr);
    @(posedge clk_i);
    while (!in_ready) begin
      if (write_ready) begin
        $display("error at %0t ns: write_ready_o is 1, expected 0 in the sweep", $time);
        tb_errors++;
      end
      blocked++;
      @(posedge clk_i);
    end
    if (blocked != LINE_COUNT) begin
      $display("error at %0t ns: in_ready_o low for %0d cycles, expected %0d",
               $time, blocked, LINE_COUNT);
      tb_errors++;
    end
  endtask

  // Ends on a falling edge with no lookup in flight
  task automatic idle_wait();
    @(negedge clk_i);
    in_valid = 1'b0;
    while (outstanding != 0) @(negedge clk_i);
  endtask

  task automatic issue_refill(input index_t idx, input set_t way, input tag_t tag,
                              input line_t data, input logic err);
    idle_wait();
    refill.index = idx;
    refill.cset  = way;
    refill.tag   = tag;
    refill.data  = data;
    refill.error = err;
    write_valid  = 1'b1;
    @(posedge clk_i);
    while (!write_ready) @(posedge clk_i);
    model_tag[way][idx]  = '{valid: 1'b1, error: err, tag: tag};
    model_data[way][idx] = data;
    @(negedge clk_i);
    write_valid = 1'b0;
  endtask

  task automatic random_refill();
    logic [31:0] r;
    line_t       d;
    next_random(r);
    random_line(d);
    issue_refill(index_t'(r[5:4]), r[6], pool_tag(r[9:8]), d, r[12]);
  endtask

  task automatic flush_cache();
    idle_wait();
    flush_valid = 1'b1;
    @(negedge clk_i);
    flush_valid = 1'b0;
    clear_model();
  endtask

  // ---------------------------------------------------------------------------
  // Clock, ready pattern and timeout
  // ---------------------------------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  initial begin
    ready_rng = 32'hc66d ^ 32'h9e37_79b9;
    out_ready = 1'b1;
    forever begin
      @(negedge clk_i);
      ready_rng = xorshift32(ready_rng);
      out_ready = random_ready ? ready_rng[3] : 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles with %0d lookups outstanding",
               cycle_count, outstanding);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------
  initial begin
    addr_t       a;
    line_t       d;
    logic [31:0] r;
    rst_ni       = 1'b0;
    flush_valid  = 1'b0;
    in_req       = '0;
    in_valid     = 1'b0;
    refill       = '0;
    write_valid  = 1'b0;
    expected     = '0;
    random_ready = 1'b0;
    rng          = 32'hc66d;
    next_id      = '0;
    tb_errors    = 0;
    clear_model();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;

    // Reset sweep blocks lookups, then everything misses
    blocked_lookup(make_addr(pool_tag(0), 4'd5, 3'd0));
    for (int i = 0; i < 4; i++) begin
      random_addr(a);
      issue_lookup(a);
    end

    // Single refills hit in their way with their data and error flag
    random_line(d);
    issue_refill(4'd5, 1'b1, pool_tag(0), d, 1'b1);
    issue_lookup(make_addr(pool_tag(0), 4'd5, 3'd4));
    random_line(d);
    issue_refill(4'd6, 1'b0, pool_tag(1), d, 1'b0);
    issue_lookup(make_addr(pool_tag(1), 4'd6, 3'd7));

    // Both ways of one index, then the same tag twice
    random_line(d);
    issue_refill(4'd9, 1'b0, pool_tag(2), d, 1'b0);
    random_line(d);
    issue_refill(4'd9, 1'b1, pool_tag(3), d, 1'b1);
    issue_lookup(make_addr(pool_tag(2), 4'd9, 3'd1));
    issue_lookup(make_addr(pool_tag(3), 4'd9, 3'd2));
    issue_lookup(make_addr(pool_tag(1), 4'd9, 3'd3));
    random_line(d);
    issue_refill(4'd9, 1'b1, pool_tag(2), d, 1'b0);
    issue_lookup(make_addr(pool_tag(2), 4'd9, 3'd0));

    // Flush clears every line
    flush_cache();
    blocked_lookup(make_addr(pool_tag(0), 4'd5, 3'd0));
    issue_lookup(make_addr(pool_tag(1), 4'd6, 3'd0));
    issue_lookup(make_addr(pool_tag(2), 4'd9, 3'd0));
    issue_lookup(make_addr(pool_tag(3), 4'd9, 3'd0));

    // Back-to-back stream under random back-pressure
    for (int i = 0; i < PRIME_LEN; i++) begin
      random_refill();
    end
    @(posedge clk_i);
    random_ready = 1'b1;
    for (int i = 0; i < STREAM_LEN; i++) begin
      random_addr(a);
      issue_lookup(a);
    end

    // Random mix, refills only into an empty pipeline
    for (int i = 0; i < MIX_LEN; i++) begin
      next_random(r);
      if (r[1:0] == 2'd0) begin
        random_refill();
      end else begin
        random_addr(a);
        issue_lookup(a);
      end
    end
    idle_wait();

    $display("checked %0d responses, %0d value errors, %0d protocol errors, %0d other errors",
             checked, value_errors, protocol_errors, tb_errors);
    if (value_errors + protocol_errors + tb_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
source/icache_lookup_pkg.sv
source/sp_ram.sv
source/tag_stage.sv
source/data_stage.sv
source/icache_lookup.sv
tests/lookup_checker.sv
tests/tb_icache_lookup.sv

// File: run.sh
#!/bin/sh
# Build the lookup testbench with Verilator, run it and check the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_icache_lookup --Mdir obj_dir -o tb_icache_lookup \
  && ./obj_dir/tb_icache_lookup > sim.log 2>&1
grep -q "^RESULT: PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
